// ==== Bender.yml ====
package:
  name: daq_top

sources:
  - daqPkg.sv
  - triggerCounter.sv
  - slaveDaq.sv
  - daqFramer.sv
  - daqTop.sv
  - target: test
    files:
      - daqTop_props.sv
      - tb_daqTop.sv

// ==== daqFramer.sv ====
`timescale 1ns/1ps
`default_nettype none

module daqFramer #(
	parameter int unsigned FIFO_DEPTH = 16 // Power of two
) (
	input wire Clk,
	input wire reset_n,
	input wire [15:0] asicData,
	input wire asicDataEn, // No handshake, cannot stall
	input wire daqPkg::frameReq_t frameReq,
	input wire reqValid,
	input wire [daqPkg::TRIG_COUNT_W-1:0] trigCount,
	input wire daqReady,
	output logic reqReady,
	output logic frameDone,
	output daqPkg::daqWord_u daqData,
	output logic daqValid,
	output logic overflow
);
	import daqPkg::*;

	localparam int unsigned AW = $clog2(FIFO_DEPTH);

	logic [15:0] fifoMem [FIFO_DEPTH];
	logic [AW:0] wrPtr; // Extra bit tells full from empty
	logic [AW:0] rdPtr;
	logic fifoEmpty;
	logic fifoFull;
	logic push;
	logic pop;
	logic take;
	logic accept;
	logic startFrame;
	logic hit;
	logic frameActive;
	frameKind_e frameKind;
	logic [1:0] wordIdx;
	logic lastWord;
	logic [TRIG_COUNT_W-1:0] countQ;
	daqWord_u frameWord;

	//////////////////////////////////////////////////////////////////////
	// ASIC word FIFO

	assign fifoEmpty = (wrPtr == rdPtr);
	assign fifoFull = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);
	assign push = asicDataEn && !fifoFull;
	assign take = daqValid && daqReady;
	assign pop = take && !frameActive; // Head word leaves only outside a frame

	always_ff @(posedge Clk) begin
		if (push)
			fifoMem[wrPtr[AW-1:0]] <= asicData;
	end

	//////////////////////////////////////////////////////////////////////
	// Request handling and frame words

	// Requests wait until all data ahead of them has gone out
	assign reqReady = fifoEmpty && !frameActive;
	assign accept = reqValid && reqReady;
	assign startFrame = accept && (frameReq.kind == TRAILER || hit);
	assign lastWord = (frameKind == TRAILER) ? (wordIdx == 2'd3) : (wordIdx == 2'd1);
	assign frameDone = frameActive && take && lastWord;

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			wrPtr <= '0;
			rdPtr <= '0;
			overflow <= 1'b0;
			hit <= 1'b0;
			frameActive <= 1'b0;
			frameKind <= TRIG_ID;
			wordIdx <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (asicDataEn && fifoFull)
				overflow <= 1'b1; // Sticky until reset
			if (asicDataEn)
				hit <= 1'b1;
			else if (accept)
				hit <= 1'b0;
			if (startFrame) begin
				frameActive <= 1'b1;
				frameKind <= frameReq.kind;
				wordIdx <= '0;
			end else if (frameActive && take) begin
				if (lastWord)
					frameActive <= 1'b0;
				wordIdx <= wordIdx + 2'd1;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (accept)
			countQ <= trigCount; // Count frozen for the whole frame
	end

	always_comb begin
		frameWord.raw = countQ[15:0]; // Count low half unless overridden
		case (frameKind)
			TRIG_ID: begin
				if (wordIdx == 2'd0) begin
					frameWord.tagWord.tag = TAG_TRIG_ID;
					frameWord.tagWord.value = countQ[TRIG_COUNT_W-1 -: 8];
				end
			end
			TRAILER: begin
				case (wordIdx)
					2'd0: frameWord.raw = TRAILER_HEAD;
					2'd1: begin
						frameWord.tagWord.tag = TAG_COUNT;
						frameWord.tagWord.value = countQ[TRIG_COUNT_W-1 -: 8];
					end
					2'd3: frameWord.raw = TRAILER_TAIL;
					default: frameWord.raw = countQ[15:0];
				endcase
			end
			default: frameWord.raw = countQ[15:0];
		endcase
	end

	// Output mux, frame words win over queued data
	assign daqValid = frameActive || !fifoEmpty;

	always_comb begin
		if (frameActive)
			daqData = frameWord;
		else
			daqData.raw = fifoMem[rdPtr[AW-1:0]];
	end

endmodule

`default_nettype wire

// ==== daqPkg.sv ====
`default_nettype none

package daqPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and frame constants

	localparam int unsigned TRIG_COUNT_W = 24; // Trigger count width

	localparam logic [7:0] TAG_TRIG_ID = 8'hF1; // Head of the trigger-ID pair
	localparam logic [7:0] TAG_COUNT = 8'hCC; // Trailer count, high byte
	localparam logic [15:0] TRAILER_HEAD = 16'hFF45;
	localparam logic [15:0] TRAILER_TAIL = 16'h45FF;

	//////////////////////////////////////////////////////////////////////
	// ASIC control lines

	typedef struct packed {
		logic resetB; // Digital part reset, active low
		logic startAcq; // Acquisition window
		logic forceExternalRaz; // High while no acquisition runs
		logic startReadout; // Digital RAM readout start
		logic pwrOnA; // Analogue power pulsing
		logic pwrOnD; // Digital power pulsing
		logic pwrOnDac; // DAC power pulsing
	} asicCtrl_t;

	// Frame requests from the sequencer to the framer
	typedef enum logic {
		TRIG_ID = 1'b0,
		TRAILER = 1'b1
	} frameKind_e;

	typedef struct packed {
		frameKind_e kind;
	} frameReq_t;

	// Output word, either a raw ASIC word or a tag byte plus a value byte
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] tag;
			logic [7:0] value;
		} tagWord;
	} daqWord_u;

endpackage

`default_nettype wire

// ==== daqTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module daqTop #(
	parameter int unsigned POWER_RESET_CYCLES = 8,
	parameter int unsigned RESET_START_CYCLES = 40,
	parameter int unsigned SRO_CYCLES = 16,
	parameter int unsigned DATA_END_CYCLES = 1600,
	parameter int unsigned FIFO_DEPTH = 16
) (
	input wire Clk,
	input wire reset_n,
	input wire moduleStart,
	input wire acqStart,
	input wire chipSatB,
	input wire endReadout,
	input wire [15:0] acquisitionTime,
	input wire [15:0] endHoldTime,
	input wire [15:0] asicData,
	input wire asicDataEn,
	input wire daqReady,
	input wire dataTransmitDone,
	output daqPkg::asicCtrl_t asicCtrl,
	output logic onceEnd,
	output logic allDone,
	output daqPkg::daqWord_u daqData,
	output logic daqValid,
	output logic overflow
);
	import daqPkg::*;

	logic trigPulse;
	logic [TRIG_COUNT_W-1:0] trigCount;
	logic countEn;
	logic countClr;
	frameReq_t frameReq;
	logic reqValid;
	logic reqReady;
	logic frameDone;

	slaveDaq #(
		.POWER_RESET_CYCLES(POWER_RESET_CYCLES),
		.RESET_START_CYCLES(RESET_START_CYCLES),
		.SRO_CYCLES(SRO_CYCLES),
		.DATA_END_CYCLES(DATA_END_CYCLES)
	) uSlaveDaq (
		.Clk, .reset_n,
		.moduleStart, .chipSatB, .endReadout, .trigPulse,
		.acquisitionTime, .endHoldTime,
		.reqReady, .frameDone, .dataTransmitDone,
		.asicCtrl, .countEn, .countClr, .frameReq, .reqValid,
		.onceEnd, .allDone
	);

	triggerCounter uTriggerCounter (
		.Clk, .reset_n,
		.acqStart, .countEn, .countClr,
		.trigPulse, .trigCount
	);

	daqFramer #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) uDaqFramer (
		.Clk, .reset_n,
		.asicData, .asicDataEn,
		.frameReq, .reqValid, .trigCount, .daqReady,
		.reqReady, .frameDone, .daqData, .daqValid, .overflow
	);

endmodule

`default_nettype wire

// ==== daqTop_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module daqTop_props (
	input wire Clk,
	input wire reset_n,
	input wire daqPkg::asicCtrl_t asicCtrl,
	input wire daqPkg::daqWord_u daqData,
	input wire daqValid,
	input wire daqReady,
	input wire daqPkg::frameReq_t frameReq,
	input wire reqValid,
	input wire reqReady
);

	// Output word holds while the host stalls
	stallHold: assert property (@(posedge Clk) disable iff (!reset_n)
		daqValid && !daqReady |=> daqValid && $stable(daqData))
		else $error("daqValid or daqData changed while daqReady was low");

	// Request holds with its payload until it is taken
	reqHold: assert property (@(posedge Clk) disable iff (!reset_n)
		reqValid && !reqReady |=> reqValid && $stable(frameReq))
		else $error("frame request dropped or changed before reqReady");

	startInReset: assert property (@(posedge Clk) disable iff (!reset_n)
		$rose(asicCtrl.startAcq) |-> asicCtrl.resetB)
		else $error("startAcq rose while resetB was low");

	//////////////////////////////////////////////////////////////////////
	// Window and readout never overlap

	windowVsReadout: assert property (@(posedge Clk) disable iff (!reset_n)
		!(asicCtrl.startAcq && asicCtrl.startReadout))
		else $error("startAcq and startReadout high together");

endmodule

bind daqTop daqTop_props props (
	.Clk, .reset_n,
	.asicCtrl, .daqData, .daqValid, .daqReady,
	.frameReq, .reqValid, .reqReady
);

`default_nettype wire

// ==== slaveDaq.sv ====
`timescale 1ns/1ps
`default_nettype none

module slaveDaq #(
	parameter int unsigned POWER_RESET_CYCLES = 8,
	parameter int unsigned RESET_START_CYCLES = 40,
	parameter int unsigned SRO_CYCLES = 16,
	parameter int unsigned DATA_END_CYCLES = 1600
) (
	input wire Clk,
	input wire reset_n,
	input wire moduleStart, // From host, asynchronous
	input wire chipSatB, // Chip full, active low, asynchronous
	input wire endReadout, // Readout finished, asynchronous
	input wire trigPulse,
	input wire [15:0] acquisitionTime,
	input wire [15:0] endHoldTime,
	input wire reqReady,
	input wire frameDone,
	input wire dataTransmitDone,
	output daqPkg::asicCtrl_t asicCtrl,
	output logic countEn,
	output logic countClr,
	output daqPkg::frameReq_t frameReq,
	output logic reqValid,
	output logic onceEnd,
	output logic allDone
);
	import daqPkg::*;

	localparam logic [3:0] S_IDLE = 4'd0,
		S_CHIP_RESET = 4'd1,
		S_POWER_ON = 4'd2,
		S_RELEASE = 4'd3,
		S_WAIT_START = 4'd4,
		S_ACQUIRE = 4'd5,
		S_WAIT_READ = 4'd6,
		S_START_READOUT = 4'd7,
		S_WAIT_READ_DONE = 4'd8,
		S_ONCE_END = 4'd9,
		S_WAIT_DATA_END = 4'd10,
		S_TRAILER = 4'd11,
		S_ALL_DONE = 4'd12;

	// Last value of the delay counter in each timed state
	localparam logic [15:0] PWR_LAST = 16'(POWER_RESET_CYCLES);
	localparam logic [15:0] RST_LAST = 16'(RESET_START_CYCLES);
	localparam logic [15:0] SRO_LAST = 16'(SRO_CYCLES);
	localparam logic [15:0] END_LAST = 16'(DATA_END_CYCLES - 1);

	logic [3:0] state;
	logic [15:0] delayCnt;
	logic resetB;
	logic startAcq;
	logic startReadout;

	logic [2:0] syncA; // {moduleStart, chipSatB, endReadout}
	logic [2:0] syncB;
	logic [1:0] syncC; // History for the edge detectors
	logic runOn;
	logic chipFull;
	logic readStart;
	logic endRead;

	//////////////////////////////////////////////////////////////////////
	// Input synchronizers and edge detection

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			syncA <= 3'b010; // chipSatB idles high
			syncB <= 3'b010;
			syncC <= 2'b10;
		end else begin
			syncA <= {moduleStart, chipSatB, endReadout};
			syncB <= syncA;
			syncC <= syncB[1:0];
		end
	end

	assign runOn = syncB[2];
	assign chipFull = !syncB[1] && syncC[1]; // Falling edge, chip is full
	assign readStart = syncB[1] && !syncC[1]; // Rising edge, readout may start
	assign endRead = syncB[0] && !syncC[0];

	//////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= S_IDLE;
			delayCnt <= '0;
			resetB <= 1'b1;
			startAcq <= 1'b0;
			startReadout <= 1'b0;
			onceEnd <= 1'b0;
			allDone <= 1'b0;
			reqValid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (runOn) begin
						resetB <= 1'b0;
						delayCnt <= '0;
						state <= S_CHIP_RESET;
					end
				end
				S_CHIP_RESET: state <= S_POWER_ON;
				S_POWER_ON: begin
					if (delayCnt < PWR_LAST) begin
						delayCnt <= delayCnt + 16'd1;
					end else begin
						delayCnt <= '0;
						resetB <= 1'b1; // Release the digital part
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (delayCnt < RST_LAST) begin
						delayCnt <= delayCnt + 16'd1;
					end else begin
						delayCnt <= '0;
						state <= S_WAIT_START;
					end
				end
				S_WAIT_START: begin
					if (!runOn) begin
						delayCnt <= '0;
						state <= S_WAIT_DATA_END;
					end else if (trigPulse) begin
						startAcq <= 1'b1;
						delayCnt <= '0;
						state <= S_ACQUIRE;
					end
				end
				S_ACQUIRE: begin
					// Window closes on timeout or when the chip is full
					if (delayCnt >= acquisitionTime || chipFull) begin
						startAcq <= 1'b0;
						delayCnt <= '0;
						state <= S_WAIT_READ;
					end else begin
						delayCnt <= delayCnt + 16'd1;
					end
				end
				S_WAIT_READ: begin
					if (readStart) begin
						startReadout <= 1'b1;
						state <= S_START_READOUT;
					end
				end
				S_START_READOUT: begin
					if (delayCnt < SRO_LAST) begin
						delayCnt <= delayCnt + 16'd1;
					end else begin
						delayCnt <= '0;
						startReadout <= 1'b0;
						state <= S_WAIT_READ_DONE;
					end
				end
				S_WAIT_READ_DONE: begin
					if (endRead) begin
						onceEnd <= 1'b1;
						state <= S_ONCE_END;
					end
				end
				S_ONCE_END: begin
					if (reqValid) begin
						if (reqReady) begin // Trigger ID handed over
							reqValid <= 1'b0;
							state <= S_WAIT_START;
						end
					end else if (delayCnt < endHoldTime) begin
						delayCnt <= delayCnt + 16'd1;
					end else begin
						delayCnt <= '0;
						onceEnd <= 1'b0;
						reqValid <= 1'b1;
					end
				end
				S_WAIT_DATA_END: begin
					// Let the last data words drain before the trailer
					if (delayCnt < END_LAST) begin
						delayCnt <= delayCnt + 16'd1;
					end else begin
						delayCnt <= '0;
						reqValid <= 1'b1;
						state <= S_TRAILER;
					end
				end
				S_TRAILER: begin
					if (reqValid) begin
						if (reqReady)
							reqValid <= 1'b0;
					end else if (frameDone) begin
						allDone <= 1'b1;
						state <= S_ALL_DONE;
					end
				end
				S_ALL_DONE: begin
					if (dataTransmitDone) begin
						allDone <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Counter control follows the run
	assign countEn = state inside {[S_WAIT_START:S_ONCE_END]};
	assign countClr = (state == S_CHIP_RESET);

	always_comb begin
		frameReq.kind = (state == S_TRAILER) ? TRAILER : TRIG_ID;
	end

	// Power lines come straight from the state
	always_comb begin
		asicCtrl.resetB = resetB;
		asicCtrl.startAcq = startAcq;
		asicCtrl.forceExternalRaz = !startAcq;
		asicCtrl.startReadout = startReadout;
		asicCtrl.pwrOnA = state inside {[S_CHIP_RESET:S_ONCE_END]};
		asicCtrl.pwrOnD = state inside {[S_POWER_ON:S_ONCE_END]};
		asicCtrl.pwrOnDac = state inside {[S_CHIP_RESET:S_ONCE_END]};
	end

endmodule

`default_nettype wire

// ==== sources.f ====
daqPkg.sv
triggerCounter.sv
slaveDaq.sv
daqFramer.sv
daqTop.sv
daqTop_props.sv
tb_daqTop.sv

// ==== tb_daqTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_daqTop;
	import daqPkg::*;

	localparam int unsigned POWER_RESET_CYCLES = 4;
	localparam int unsigned RESET_START_CYCLES = 8;
	localparam int unsigned SRO_CYCLES = 4;
	localparam int unsigned DATA_END_CYCLES = 40;
	localparam int unsigned FIFO_DEPTH = 16;
	localparam int unsigned ACQ_TIME = 20;
	localparam int unsigned END_HOLD = 6;
	localparam int unsigned SAT_DELAY = 5; // Window cycles before the chip reports full
	localparam int unsigned NUM_ROWS = 6;

	typedef struct packed {
		logic [7:0] words; // Hit words in the readout
		logic bySat; // Window ends on chipSatB or else on timeout
		logic backPressure; // Random daqReady
	} rowSpec_t;

	localparam rowSpec_t ROWS [NUM_ROWS] = '{
		'{8'd4, 1'b1, 1'b0},
		'{8'd0, 1'b0, 1'b0},
		'{8'd6, 1'b0, 1'b1},
		'{8'd0, 1'b1, 1'b1},
		'{8'd12, 1'b1, 1'b1},
		'{8'd3, 1'b0, 1'b0}
	};

	logic Clk;
	logic reset_n;
	logic moduleStart;
	logic acqStart;
	logic chipSatB;
	logic endReadout;
	logic [15:0] acquisitionTime;
	logic [15:0] endHoldTime;
	logic [15:0] asicData;
	logic asicDataEn;
	logic daqReady;
	logic dataTransmitDone;
	asicCtrl_t asicCtrl;
	logic onceEnd;
	logic allDone;
	daqWord_u daqData;
	logic daqValid;
	logic overflow;

	logic [31:0] lfsr = 32'h3b802457;
	daqWord_u expQ [$]; // Scoreboard of words in output order
	int nChecks = 0;
	int errCount = 0;
	int rowGot = 0;
	int cycleCount = 0;
	logic throttle = 1'b0;

	daqTop #(
		.POWER_RESET_CYCLES(POWER_RESET_CYCLES),
		.RESET_START_CYCLES(RESET_START_CYCLES),
		.SRO_CYCLES(SRO_CYCLES),
		.DATA_END_CYCLES(DATA_END_CYCLES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut (
		.Clk, .reset_n,
		.moduleStart, .acqStart, .chipSatB, .endReadout,
		.acquisitionTime, .endHoldTime, .asicData, .asicDataEn,
		.daqReady, .dataTransmitDone,
		.asicCtrl, .onceEnd, .allDone, .daqData, .daqValid, .overflow
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int runBudget();
		int total;
		total = 100 + POWER_RESET_CYCLES + RESET_START_CYCLES + DATA_END_CYCLES;
		for (int r = 0; r < NUM_ROWS; r++)
			total += ACQ_TIME + END_HOLD + SRO_CYCLES + 60 + 4 * int'(ROWS[r].words);
		return total;
	endfunction

	// Wait one clock and drive daqReady for the new cycle
	task automatic stepCycle();
		logic [15:0] bits;
		@(posedge Clk);
		#10;
		if (throttle) begin
			bits = randomBits(1);
			daqReady = bits[0];
		end else begin
			daqReady = 1'b1;
		end
	endtask

	task automatic expectBit(input string what, input logic got, input logic want);
		nChecks++;
		assert (got === want) else begin
			$display("Error %0t ns: %s is %b, expected %b", $time, what, got, want);
			errCount++;
		end
	endtask

	task automatic compareNum(input string what, input int got, input int want);
		nChecks++;
		assert (got == want) else begin
			$display("Error %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			errCount++;
		end
	endtask

	task automatic scoreWord(input daqWord_u got);
		daqWord_u exp;
		nChecks++;
		rowGot++;
		assert (expQ.size() > 0) else begin
			$display("Error %0t ns: output word %h arrived but none was expected",
				$time, got.raw);
			errCount++;
			return;
		end
		exp = expQ.pop_front();
		assert (got.raw === exp.raw) else begin
			$display("Error %0t ns: word %h (tag %h value %h), expected %h", $time,
				got.raw, got.tagWord.tag, got.tagWord.value, exp.raw);
			errCount++;
		end
	endtask

	// Output words are taken where daqValid and daqReady meet
	always @(negedge Clk) begin
		if (reset_n === 1'b1 && daqValid && daqReady)
			scoreWord(daqData);
	end

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > runBudget()) begin
			$display("Timeout: run did not finish within %0d cycles", runBudget());
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int winLen;
		int holdLen;
		int rowErr;
		rowSpec_t row;
		daqWord_u w;
		asicCtrl_t idleCtrl;
		logic [23:0] total;

		reset_n = 1'b0;
		moduleStart = 1'b0;
		acqStart = 1'b0;
		chipSatB = 1'b1; // Chip not full
		endReadout = 1'b0;
		acquisitionTime = 16'(ACQ_TIME);
		endHoldTime = 16'(END_HOLD);
		asicData = '0;
		asicDataEn = 1'b0;
		daqReady = 1'b1;
		dataTransmitDone = 1'b0;
		repeat (4) @(posedge Clk);
		#10;
		reset_n = 1'b1;

		// Idle outputs after reset
		rowErr = errCount;
		stepCycle();
		idleCtrl = '0;
		idleCtrl.resetB = 1'b1;
		idleCtrl.forceExternalRaz = 1'b1;
		compareNum("asicCtrl", int'(asicCtrl), int'(idleCtrl));
		expectBit("onceEnd", onceEnd, 1'b0);
		expectBit("allDone", allDone, 1'b0);
		expectBit("daqValid", daqValid, 1'b0);
		expectBit("overflow", overflow, 1'b0);

		// Power-up and chip reset
		moduleStart = 1'b1;
		while (asicCtrl.resetB)
			stepCycle();
		holdLen = 0;
		while (!asicCtrl.resetB) begin
			holdLen++;
			stepCycle();
		end
		compareNum("resetB low cycles", holdLen, POWER_RESET_CYCLES + 2);
		repeat (RESET_START_CYCLES + 2) stepCycle(); // Sequencer armed
		$display("reset and power-up: %s", errCount == rowErr ? "ok" : "errors");

		for (int r = 0; r < NUM_ROWS; r++) begin
			row = ROWS[r];
			rowErr = errCount;
			rowGot = 0;
			throttle = row.backPressure;

			acqStart = 1'b1;
			repeat (2) stepCycle();
			acqStart = 1'b0;
			while (!asicCtrl.startAcq)
				stepCycle();
			winLen = 0;
			while (asicCtrl.startAcq) begin
				expectBit("startReadout in window", asicCtrl.startReadout, 1'b0);
				expectBit("forceExternalRaz in window", asicCtrl.forceExternalRaz, 1'b0);
				compareNum("power lines in window",
					int'({asicCtrl.pwrOnA, asicCtrl.pwrOnD, asicCtrl.pwrOnDac}), 7);
				winLen++;
				if (row.bySat && winLen == SAT_DELAY)
					chipSatB = 1'b0; // Chip full
				stepCycle();
			end
			if (row.bySat) begin
				nChecks++;
				assert (winLen < ACQ_TIME + 1) else begin
					$display("Error %0t ns: window of %0d cycles ignored chipSatB",
						$time, winLen);
					errCount++;
				end
			end else begin
				compareNum("window cycles", winLen, ACQ_TIME + 1);
			end

			// ASIC model does the conversion and then the readout
			chipSatB = 1'b0;
			repeat (4) stepCycle();
			chipSatB = 1'b1;
			while (!asicCtrl.startReadout)
				stepCycle();
			for (int i = 0; i < int'(row.words); i++) begin
				w.raw = randomBits(16);
				asicData = w.raw;
				asicDataEn = 1'b1;
				expQ.push_back(w);
				stepCycle();
			end
			asicDataEn = 1'b0;
			asicData = '0;
			total = 24'(r + 1); // Triggers so far
			if (row.words > 0) begin
				w.tagWord.tag = TAG_TRIG_ID;
				w.tagWord.value = total[23:16];
				expQ.push_back(w);
				w.raw = total[15:0];
				expQ.push_back(w);
			end
			while (asicCtrl.startReadout)
				stepCycle();
			endReadout = 1'b1;
			while (!onceEnd)
				stepCycle();
			endReadout = 1'b0;
			holdLen = 0;
			while (onceEnd) begin
				holdLen++;
				stepCycle();
			end
			compareNum("onceEnd cycles", holdLen, END_HOLD + 1);

			while (expQ.size() > 0 || daqValid)
				stepCycle();
			repeat (4) stepCycle(); // Request taken and sequencer back in wait-start
			expectBit("overflow", overflow, 1'b0);
			compareNum("words out", rowGot, int'(row.words) + (row.words > 0 ? 2 : 0));
			$display("row %0d: %0d hit words, %s end, back-pressure %s: %s", r,
				row.words, row.bySat ? "chipSatB" : "timeout",
				row.backPressure ? "on" : "off", errCount == rowErr ? "ok" : "errors");
		end

		//////////////////////////////////////////////////////////////////////
		// Run end and trailer

		rowErr = errCount;
		rowGot = 0;
		throttle = 1'b1;
		moduleStart = 1'b0;
		total = 24'(NUM_ROWS);
		w.raw = TRAILER_HEAD;
		expQ.push_back(w);
		w.tagWord.tag = TAG_COUNT;
		w.tagWord.value = total[23:16];
		expQ.push_back(w);
		w.raw = total[15:0];
		expQ.push_back(w);
		w.raw = TRAILER_TAIL;
		expQ.push_back(w);
		while (!allDone)
			stepCycle();
		compareNum("trailer words pending", expQ.size(), 0);
		compareNum("trailer words out", rowGot, 4);
		repeat (8) begin
			expectBit("allDone before ack", allDone, 1'b1);
			stepCycle();
		end
		dataTransmitDone = 1'b1;
		stepCycle();
		dataTransmitDone = 1'b0;
		expectBit("allDone after ack", allDone, 1'b0);
		compareNum("asicCtrl after run", int'(asicCtrl), int'(idleCtrl));
		$display("run end: trailer count %0d, allDone handshake: %s", NUM_ROWS,
			errCount == rowErr ? "ok" : "errors");

		$display("%0d checks, %0d errors", nChecks, errCount);
		if (errCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== triggerCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module triggerCounter (
	input wire Clk,
	input wire reset_n,
	input wire acqStart, // External trigger, asynchronous
	input wire countEn,
	input wire countClr,
	output logic trigPulse,
	output logic [daqPkg::TRIG_COUNT_W-1:0] trigCount
);

	logic acqMeta;
	logic acqSync;
	logic acqLast;
	logic risingEdge;

	// Two-stage synchronizer plus one history stage for the edge
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			acqMeta <= 1'b0;
			acqSync <= 1'b0;
			acqLast <= 1'b0;
		end else begin
			acqMeta <= acqStart;
			acqSync <= acqMeta;
			acqLast <= acqSync;
		end
	end

	assign risingEdge = acqSync && !acqLast;

	// Pulse and count leave together, three cycles after the trigger
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			trigPulse <= 1'b0;
			trigCount <= '0;
		end else begin
			trigPulse <= risingEdge;
			if (countClr)
				trigCount <= '0; // New run
			else if (risingEdge && countEn)
				trigCount <= trigCount + 1'b1;
		end
	end

endmodule

`default_nettype wire
